// File: bench/sap_chk.sv
// Concurrent checks on the sequencer, attached to every sap_sequencer by the bind below
`timescale 1ns/1ps

module sap_chk
    import sap_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       run,
    input logic       halted,
    input stage_e     stage,
    input ctrl_word_t ctrl
);

    stage_range: assert property (@(posedge clk) disable iff (!rst_n) stage <= T5)
        else $error("sequencer stage left the range T0 to T5");

    // PC, IR operand, RAM, A and adder share one bus
    one_driver: assert property (@(posedge clk) disable iff (!rst_n)
        $countones({ctrl.pc_en, !ctrl.ir_en_n, !ctrl.ram_en_n, ctrl.rega_en, ctrl.regb_en}) <= 1)
        else $error("more than one bus driver enabled");

    halt_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        (halted && $past(halted)) |-> $stable(stage))
        else $error("stage moved while halted");

    // A stopped machine waits in fetch with halt cleared
    idle_stopped: assert property (@(posedge clk) disable iff (!rst_n)
        !run |-> (ctrl == CTRL_IDLE && stage == T0 && !halted))
        else $error("stopped sequencer not idle in T0 with halt cleared");

endmodule

bind sap_sequencer sap_chk u_sap_chk (
    .clk    (clk),
    .rst_n  (rst_n),
    .run    (run),
    .halted (halted),
    .stage  (stage),
    .ctrl   (ctrl)
);

// File: bench/sap_patterns.txt
# W offset value pslverr | R offset expected pslverr | E output | H wait halt | S stop
# Hex fields; RAM at 00-0F, CTRL 10, STATUS 11, OUT 12, OUT_COUNT 13; opcode in the high nibble
R 11 00 0
R 12 00 0
R 13 00 0
W 00 49 0
W 01 2a 0
W 02 50 0
W 03 3b 0
W 04 50 0
W 05 6e 0
W 06 00 0
W 09 f0 0
W 0a 20 0
W 0b 30 0
E 10
E e0
W 10 01 0
H
R 11 01 0
R 13 02 0
R 12 e0 0
R 0e 00 1
W 10 00 0
R 11 00 0
R 0e e0 0
W 07 70 0
W 00 4c 0
W 01 73 0
W 03 2d 0
W 05 00 0
W 0c 7f 0
W 0d 05 0
E 84
W 10 01 0
W 02 ab 1
H
R 13 03 0
R 12 84 0
W 10 00 0
R 02 50 0
R 20 00 1
S

// File: bench/tb_checker.sv
// Testbench checker; compares APB responses and each new output value with the expected ones
`timescale 1ns/1ps

module tb_checker
    import sap_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  apb_req_t   apb,
    input  apb_rsp_t   apb_rsp,
    input  logic [7:0] out_value,
    input  logic [7:0] out_count,
    input  logic       exp_push,
    input  logic [7:0] exp_value,
    input  logic       check_en,
    input  logic [7:0] rd_expect,
    input  logic       err_expect,
    output int         errors,
    output int         pending
);

    logic [7:0] exp_q[$];       // Outputs still to come, in order
    logic [7:0] last_count;
    logic       started;
    int         apb_errs = 0;
    int         out_errs = 0;

    assign errors = apb_errs + out_errs;

    // Access cycle ends at this edge
    always @(posedge clk) begin
        if (check_en && apb.psel && apb.penable) begin
            if (!apb.pwrite && apb_rsp.prdata !== rd_expect) begin
                $display("mismatch prdata at offset %h: got %h expected %h",
                         apb.paddr, apb_rsp.prdata, rd_expect);
                apb_errs++;
            end
            if (apb_rsp.pslverr !== err_expect) begin
                $display("mismatch pslverr at offset %h: got %h expected %h",
                         apb.paddr, apb_rsp.pslverr, err_expect);
                apb_errs++;
            end
        end
    end

    // Outputs move only at rising edges
    always @(negedge clk) begin
        logic [7:0] want;
        if (exp_push) begin
            exp_q.push_back(exp_value);
        end
        if (!rst_n) begin
            started    = 1'b0;
            last_count = '0;
        end else if (!started) begin
            started = 1'b1;                 // First look after reset
            if (out_value !== 8'h00) begin
                $display("mismatch out_value after reset: got %h expected 00", out_value);
                out_errs++;
            end
            if (out_count !== 8'h00) begin
                $display("mismatch out_count after reset: got %h expected 00", out_count);
                out_errs++;
            end
            last_count = out_count;
        end else if (out_count !== last_count) begin
            if (out_count !== last_count + 8'd1) begin
                $display("mismatch out_count: got %h expected %h", out_count, last_count + 8'd1);
                out_errs++;
            end
            if (exp_q.size() == 0) begin
                $display("output %h appeared with no expected value left", out_value);
                out_errs++;
            end else begin
                want = exp_q.pop_front();
                if (out_value !== want) begin
                    $display("mismatch out_value: got %h expected %h", out_value, want);
                    out_errs++;
                end
            end
            last_count = out_count;
        end
        pending = exp_q.size();
    end

endmodule

// File: bench/tb_clock.sv
// Free-running clock source for the testbench top, period set by parameter
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;    // Half period per toggle
        end
    end

endmodule

// File: bench/tb_top.sv
// Testbench top; resets the machine, replays bench/sap_patterns.txt over APB, reports the result
`timescale 1ns/1ps

module tb_top
    import sap_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 8;        // Cycles allowed for pready
    localparam int POLL_LIMIT   = 100;      // Status reads before giving up on halt
    localparam int DRAIN_LIMIT  = 200;      // Cycles for outputs still expected

    logic       clk;
    logic       rst_n;
    apb_req_t   apb;
    apb_rsp_t   apb_rsp;
    logic [7:0] out_value;
    logic [7:0] out_count;
    logic       exp_push;
    logic [7:0] exp_value;
    logic       check_en;
    logic [7:0] rd_expect;
    logic       err_expect;
    int         chk_errors;
    int         pending;
    int         timeouts;
    int         other_errs;
    logic       abort;

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

    sap_top #(
        .DATA_W (8),
        .ADDR_W (4)
    ) u_sap_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb       (apb),
        .apb_rsp   (apb_rsp),
        .out_value (out_value),
        .out_count (out_count)
    );

    tb_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb        (apb),
        .apb_rsp    (apb_rsp),
        .out_value  (out_value),
        .out_count  (out_count),
        .exp_push   (exp_push),
        .exp_value  (exp_value),
        .check_en   (check_en),
        .rd_expect  (rd_expect),
        .err_expect (err_expect),
        .errors     (chk_errors),
        .pending    (pending)
    );

    // Setup then access; starts and ends 2 ns after a rising edge
    task automatic apb_transfer(input logic wr, input logic [5:0] off, input logic [7:0] wdata,
                                input logic [7:0] exp_data, input logic exp_err,
                                input logic check, output logic [7:0] rdata);
        int n;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = wr;
        apb.paddr   = off;
        apb.pwdata  = wdata;
        @(posedge clk);
        #2;
        apb.penable = 1'b1;
        check_en    = check;
        rd_expect   = exp_data;
        err_expect  = exp_err;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!apb_rsp.pready && n < WAIT_LIMIT);
        rdata = apb_rsp.prdata;
        if (!apb_rsp.pready) begin
            $display("timeout: no pready for the transfer to offset %h", off);
            timeouts++;
            abort = 1'b1;
        end
        #2;
        apb      = '0;
        check_en = 1'b0;
    endtask

    task automatic idle_gap();
        int unsigned n;
        n = $urandom % 3;
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic push_expected(input logic [7:0] value);
        exp_value = value;
        exp_push  = 1'b1;
        @(posedge clk);
        #2;
        exp_push = 1'b0;
    endtask

    task automatic wait_halted();
        logic [7:0] status;
        int         polls;
        status = 8'h00;
        polls  = 0;
        while (!status[0] && polls < POLL_LIMIT && !abort) begin
            apb_transfer(1'b0, REG_STATUS, 8'h00, 8'h00, 1'b0, 1'b0, status);
            idle_gap();
            polls++;
        end
        if (!status[0]) begin
            $display("timeout: the machine did not halt within %0d status reads", POLL_LIMIT);
            timeouts++;
            abort = 1'b1;
        end
    endtask

    task automatic drain_outputs();
        int n;
        n = 0;
        while (pending != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (pending != 0) begin
            $display("timeout: %0d expected outputs never appeared", pending);
            timeouts++;
        end
    endtask

    initial begin
        int          fd;
        string       line;
        logic [7:0]  kind;
        logic [7:0]  f1;
        logic [7:0]  f2;
        logic [7:0]  f3;
        logic [7:0]  rdata;
        logic        done;

        void'($urandom(11445));
        rst_n      = 1'b0;
        apb        = '0;
        exp_push   = 1'b0;
        exp_value  = '0;
        check_en   = 1'b0;
        rd_expect  = '0;
        err_expect = 1'b0;
        timeouts   = 0;
        other_errs = 0;
        abort      = 1'b0;
        done       = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        fd = $fopen("bench/sap_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file bench/sap_patterns.txt");
            other_errs++;
            done = 1'b1;
        end
        while (!done && !abort && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            kind = "#";                     // Blank line reads as a comment
            f1 = '0;
            f2 = '0;
            f3 = '0;
            void'($sscanf(line, "%c %h %h %h", kind, f1, f2, f3));
            case (kind)
                "W": apb_transfer(1'b1, f1[5:0], f2, 8'h00, f3[0], 1'b1, rdata);
                "R": apb_transfer(1'b0, f1[5:0], 8'h00, f2, f3[0], 1'b1, rdata);
                "E": push_expected(f1);
                "H": wait_halted();
                "S": done = 1'b1;
                "#", "\n", "\r": ;
                default: begin
                    $display("unknown pattern record: %s", line);
                    other_errs++;
                end
            endcase
            if (kind == "W" || kind == "R") begin
                idle_gap();
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        drain_outputs();
        $display("closing: checker errors %0d, timeouts %0d, other errors %0d",
                 chk_errors, timeouts, other_errs);
        if (chk_errors + timeouts + other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: hdl/sap_datapath.sv
// Execute side of the accumulator computer: PC, MAR, RAM, IR, A, B, adder and shared bus
`timescale 1ns/1ps

module sap_datapath
    import sap_pkg::*;
#(
    parameter int DATA_W = 8,
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  ctrl_word_t        ctrl,
    input  host_mem_t         host,
    output logic [DATA_W-1:0] host_rdata,
    output opcode_e           opcode,
    output logic [DATA_W-1:0] bus_value
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] mar;
    logic [DATA_W-1:0] ram [DEPTH];
    mem_word_u         ir;
    logic [DATA_W-1:0] reg_a;
    logic [DATA_W-1:0] reg_b;
    logic [DATA_W-1:0] alu_out;
    logic [DATA_W-1:0] bus;

    logic              host_sel;
    logic [ADDR_W-1:0] ram_addr;
    logic [DATA_W-1:0] ram_rdata;

    // Host owns the RAM port on a write strobe or when the sequencer is quiet
    assign host_sel  = host.we || (ctrl == CTRL_IDLE);
    assign ram_addr  = host_sel ? host.addr : mar;
    assign ram_rdata = ram[ram_addr];

    assign alu_out = ctrl.adder_sub ? (reg_a - reg_b) : (reg_a + reg_b);   // Wraps modulo 2**DATA_W

    // One driver at a time, the microcode never enables two
    always_comb begin
        if (ctrl.pc_en) begin
            bus = DATA_W'(pc);
        end else if (!ctrl.ir_en_n) begin
            bus = DATA_W'(ir.instr.addr);       // Operand field only
        end else if (!ctrl.ram_en_n) begin
            bus = ram_rdata;
        end else if (ctrl.rega_en) begin
            bus = reg_a;
        end else if (ctrl.regb_en) begin
            bus = alu_out;
        end else begin
            bus = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (ctrl.pc_load) begin
            pc <= bus[ADDR_W-1:0];              // JMP target
        end else if (ctrl.pc_inc) begin
            pc <= pc + 1'b1;                    // Runs past HLT too
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.mar_addr_load_n) begin
            mar <= bus[ADDR_W-1:0];
        end
        if (!ctrl.ir_load_n) begin
            ir.data <= bus;
        end
        if (!ctrl.rega_load_n) begin
            reg_a <= bus;
        end
        if (!ctrl.regb_load_n) begin
            reg_b <= bus;
        end
    end

    // Host load of the program, or STA from the bus
    always_ff @(posedge clk) begin
        if (host_sel && host.we) begin
            ram[host.addr] <= host.wdata;
        end else if (!ctrl.mar_mem_load_n) begin
            ram[mar] <= bus;
        end
    end

    assign host_rdata = ram_rdata;
    assign opcode     = ir.instr.op;
    assign bus_value  = bus;

endmodule

// File: hdl/sap_pkg.sv
// Shared types for the accumulator computer; imported by every RTL block
package sap_pkg;

    typedef enum logic [3:0] {
        OP_HLT = 4'h0,
        OP_NOP = 4'h1,
        OP_ADD = 4'h2,
        OP_SUB = 4'h3,
        OP_LDA = 4'h4,
        OP_OUT = 4'h5,
        OP_STA = 4'h6,
        OP_JMP = 4'h7
    } opcode_e;

    typedef enum logic [2:0] {
        T0 = 3'd0,
        T1 = 3'd1,
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4,
        T5 = 3'd5
    } stage_e;

    // Bit order follows the classic fourteen-bit control word, pc_inc is the MSB
    typedef struct packed {
        logic pc_inc;           // Count PC up
        logic pc_en;            // PC onto bus
        logic pc_load;          // PC from bus
        logic mar_addr_load_n;  // MAR from bus
        logic mar_mem_load_n;   // RAM[MAR] from bus
        logic ram_en_n;         // RAM onto bus
        logic ir_load_n;        // IR from bus
        logic ir_en_n;          // IR operand onto bus
        logic rega_load_n;      // A from bus
        logic rega_en;          // A onto bus
        logic adder_sub;        // Subtract instead of add
        logic regb_en;          // Adder result onto bus
        logic regb_load_n;      // B from bus
        logic out_load_n;       // Output register from bus
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = 14'b00011111100011;

    // One RAM byte, read as an instruction or as plain data
    typedef union packed {
        struct packed {
            opcode_e    op;
            logic [3:0] addr;
        } instr;
        logic [7:0] data;
    } mem_word_u;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [5:0] paddr;
        logic [7:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [7:0] prdata;
        logic       pready;
        logic       pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic       we;
        logic [3:0] addr;
        logic [7:0] wdata;
    } host_mem_t;

    localparam logic [5:0] REG_RAM_BASE  = 6'h00;
    localparam logic [5:0] REG_CTRL      = 6'h10;
    localparam logic [5:0] REG_STATUS    = 6'h11;
    localparam logic [5:0] REG_OUT       = 6'h12;
    localparam logic [5:0] REG_OUT_COUNT = 6'h13;

endpackage

// File: hdl/sap_result.sv
// Output register, OUT counter and APB slave for run control, status and RAM access
`timescale 1ns/1ps

module sap_result
    import sap_pkg::*;
#(
    parameter int DATA_W = 8,
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  apb_req_t          apb,
    output apb_rsp_t          apb_rsp,
    input  ctrl_word_t        ctrl,
    input  logic [DATA_W-1:0] bus_value,
    input  logic              halted,
    output logic              run,
    output host_mem_t         host,
    input  logic [DATA_W-1:0] host_rdata,
    output logic [DATA_W-1:0] out_value,
    output logic [DATA_W-1:0] out_count
);

    logic access;
    logic wr;
    logic rd;
    logic ram_hit;
    logic wr_ok;
    logic [DATA_W-1:0] rdata;
    logic rd_err;

    assign access  = apb.psel && apb.penable;  // No wait states
    assign wr      = access && apb.pwrite;
    assign rd      = access && !apb.pwrite;
    assign ram_hit = (apb.paddr >> ADDR_W) == (REG_RAM_BASE >> ADDR_W);

    // RAM only while stopped, CTRL at any time
    assign wr_ok = (ram_hit && !run) || (apb.paddr == REG_CTRL);

    always_comb begin
        rdata  = '0;
        rd_err = 1'b0;
        if (ram_hit) begin
            if (run) begin
                rd_err = 1'b1;                  // Port belongs to the machine
            end else begin
                rdata = host_rdata;
            end
        end else begin
            case (apb.paddr)
                REG_CTRL:      rdata = DATA_W'(run);
                REG_STATUS:    rdata = DATA_W'(halted);
                REG_OUT:       rdata = out_value;
                REG_OUT_COUNT: rdata = out_count;
                default:       rd_err = 1'b1;
            endcase
        end
    end

    assign apb_rsp.prdata  = rd ? rdata : '0;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = (rd && rd_err) || (wr && !wr_ok);

    // Address also steers host reads, the strobe gates writes
    assign host.we    = wr && ram_hit && !run;
    assign host.addr  = apb.paddr[ADDR_W-1:0];
    assign host.wdata = apb.pwdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (wr && apb.paddr == REG_CTRL) begin
            run <= apb.pwdata[0];
        end
    end

    // OUT lands here in its T3 cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_value <= '0;
            out_count <= '0;
        end else if (!ctrl.out_load_n) begin
            out_value <= bus_value;
            out_count <= out_count + 1'b1;
        end
    end

endmodule

// File: hdl/sap_sequencer.sv
// Six-stage microcode sequencer; turns opcode and stage into the datapath control word
`timescale 1ns/1ps

module sap_sequencer
    import sap_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  opcode_e    opcode,
    output ctrl_word_t ctrl,
    output logic       halted
);

    stage_e     stage;
    logic       armed;      // Run seen at a falling edge
    ctrl_word_t ucode;

    // Stage moves on the falling edge so the word is settled at the rising edge
    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage  <= T0;
            armed  <= 1'b0;
            halted <= 1'b0;
        end else if (!run) begin
            stage  <= T0;       // Stopped machine waits in fetch
            armed  <= 1'b0;
            halted <= 1'b0;
        end else if (!armed) begin
            armed <= 1'b1;      // First full T0 cycle starts here
        end else if (halted) begin
            stage <= stage;     // Frozen until run drops
        end else if (stage == T3 && opcode == OP_HLT) begin
            halted <= 1'b1;
        end else if (stage == T5) begin
            stage <= T0;
        end else begin
            stage <= stage_e'(stage + 3'd1);
        end
    end

    always_comb begin
        ucode = CTRL_IDLE;
        case (stage)
            T0: begin                           // PC to MAR
                ucode.pc_en           = 1'b1;
                ucode.mar_addr_load_n = 1'b0;
            end
            T1: begin
                ucode.pc_inc = 1'b1;
            end
            T2: begin                           // RAM to IR
                ucode.ram_en_n  = 1'b0;
                ucode.ir_load_n = 1'b0;
            end
            T3: begin
                case (opcode)
                    OP_ADD, OP_SUB, OP_LDA, OP_STA: begin
                        ucode.ir_en_n         = 1'b0;
                        ucode.mar_addr_load_n = 1'b0;
                    end
                    OP_OUT: begin
                        ucode.rega_en    = 1'b1;
                        ucode.out_load_n = 1'b0;
                    end
                    OP_JMP: begin
                        ucode.ir_en_n = 1'b0;
                        ucode.pc_load = 1'b1;
                    end
                    default: ;
                endcase
            end
            T4: begin
                case (opcode)
                    OP_ADD, OP_SUB: begin       // Operand into B
                        ucode.ram_en_n    = 1'b0;
                        ucode.regb_load_n = 1'b0;
                    end
                    OP_LDA: begin
                        ucode.ram_en_n    = 1'b0;
                        ucode.rega_load_n = 1'b0;
                    end
                    OP_STA: begin
                        ucode.rega_en        = 1'b1;
                        ucode.mar_mem_load_n = 1'b0;
                    end
                    default: ;
                endcase
            end
            T5: begin
                case (opcode)
                    OP_ADD: begin
                        ucode.regb_en     = 1'b1;
                        ucode.rega_load_n = 1'b0;
                    end
                    OP_SUB: begin
                        ucode.adder_sub   = 1'b1;
                        ucode.regb_en     = 1'b1;
                        ucode.rega_load_n = 1'b0;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // Nothing reaches the datapath unless the machine is really running
    assign ctrl = (run && armed) ? ucode : CTRL_IDLE;

endmodule

// File: hdl/sap_top.sv
// Top of the accumulator computer; ties sequencer, datapath and host block together
`timescale 1ns/1ps

module sap_top
    import sap_pkg::*;
#(
    parameter int DATA_W = 8,
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  apb_req_t          apb,
    output apb_rsp_t          apb_rsp,
    output logic [DATA_W-1:0] out_value,
    output logic [DATA_W-1:0] out_count
);

    ctrl_word_t        ctrl;
    opcode_e           opcode;
    logic              run;
    logic              halted;
    host_mem_t         host;
    logic [DATA_W-1:0] host_rdata;
    logic [DATA_W-1:0] bus_value;

    sap_sequencer u_sequencer (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .opcode (opcode),
        .ctrl   (ctrl),
        .halted (halted)
    );

    sap_datapath #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .host       (host),
        .host_rdata (host_rdata),
        .opcode     (opcode),
        .bus_value  (bus_value)
    );

    sap_result #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb        (apb),
        .apb_rsp    (apb_rsp),
        .ctrl       (ctrl),
        .bus_value  (bus_value),
        .halted     (halted),
        .run        (run),
        .host       (host),
        .host_rdata (host_rdata),
        .out_value  (out_value),
        .out_count  (out_count)
    );

endmodule

// File: project.f
hdl/sap_pkg.sv
hdl/sap_sequencer.sv
hdl/sap_datapath.sv
hdl/sap_result.sv
hdl/sap_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/sap_chk.sv
bench/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f project.f -o tb_sim

# An assertion stops the simulator with a nonzero status, the log still decides
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "run.sh: simulation PASS"
    exit 0
fi
echo "run.sh: simulation FAIL"
exit 1
